/* logic/common.sv */
`default_nettype none

package common;

    // 640x480 at 60 Hz raster, in pixels and lines
    localparam logic [9:0] H_ACTIVE     = 10'd640;
    localparam logic [9:0] H_SYNC_START = 10'd656;
    localparam logic [9:0] H_SYNC_END   = 10'd752;
    localparam logic [9:0] H_TOTAL      = 10'd800;

    localparam logic [9:0] V_ACTIVE     = 10'd480;
    localparam logic [9:0] V_SYNC_START = 10'd490;
    localparam logic [9:0] V_SYNC_END   = 10'd492;
    localparam logic [9:0] V_TOTAL      = 10'd525;

    // fetch runs one tile ahead of the beam
    localparam logic [9:0] FETCH_AHEAD  = 10'd8;

    // apb address map, top two bits of paddr
    localparam logic [1:0] REGION_SCREEN = 2'd0;
    localparam logic [1:0] REGION_FONT   = 2'd1;
    localparam logic [1:0] REGION_CTRL   = 2'd2;

    typedef logic [7:0]  char_code_t;
    // leftmost pixel in bits 31:28
    typedef logic [31:0] glyph_row_t;
    // screen: {row, col[6:0]}, font: {code, glyph row}
    typedef logic [11:0] mem_addr_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [13:0] paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
        logic       hsync_n;
        logic       vsync_n;
    } vga_out_t;

endpackage

`default_nettype wire

/* logic/dual_port_ram.sv */
`timescale 1ns/1ns
`default_nettype none

module dual_port_ram #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4096
) (
    input  wire logic             clk_pxl_i,

    // port a, bus side
    input  wire logic             a_we_i,
    input  wire common::mem_addr_t a_addr_i,
    input  wire payload_t         a_wdata_i,
    output      payload_t         a_rdata_o,

    // port b, video side
    input  wire common::mem_addr_t b_addr_i,
    output      payload_t         b_rdata_o
);

    payload_t mem [DEPTH];

    // read returns the old word on a same-address write
    always_ff @(posedge clk_pxl_i) begin
        if (a_we_i) begin
            mem[a_addr_i] <= a_wdata_i;
        end
        a_rdata_o <= mem[a_addr_i];
    end

    always_ff @(posedge clk_pxl_i) begin
        b_rdata_o <= mem[b_addr_i];
    end

endmodule

`default_nettype wire

/* logic/apb_text_port.sv */
`timescale 1ns/1ns
`default_nettype none

module apb_text_port (
    input  wire logic              clk_pxl_i,
    input  wire logic              reset_i,

    // apb slave
    input  wire common::apb_req_t  apb_req_i,
    output      common::apb_rsp_t  apb_rsp_o,

    // shared port a of both memories
    output      logic              scr_we_o,
    output      logic              font_we_o,
    output      common::mem_addr_t mem_addr_o,
    output      logic [31:0]       mem_wdata_o,
    input  wire common::char_code_t scr_rdata_i,
    input  wire common::glyph_row_t font_rdata_i,

    // control register
    output      logic              enable_o
);

    logic [1:0] region_w;
    logic       access_w;
    logic       is_scr_w;
    logic       is_font_w;
    logic       is_ctrl_w;
    logic       is_unmapped_w;
    logic       mem_rd_w;
    logic       rd_wait_r;
    logic       enable_r;

    // decode
    always_comb begin
        region_w      = apb_req_i.paddr[13:12];
        access_w      = apb_req_i.psel && apb_req_i.penable;
        is_scr_w      = (region_w == common::REGION_SCREEN);
        is_font_w     = (region_w == common::REGION_FONT);
        is_ctrl_w     = (region_w == common::REGION_CTRL);
        is_unmapped_w = !(is_scr_w || is_font_w || is_ctrl_w);
        mem_rd_w      = access_w && !apb_req_i.pwrite && (is_scr_w || is_font_w);
    end

    // memory side, address and data straight from the bus
    always_comb begin
        mem_addr_o  = apb_req_i.paddr[11:0];
        mem_wdata_o = apb_req_i.pwdata;
        scr_we_o    = access_w && apb_req_i.pwrite && is_scr_w;
        font_we_o   = access_w && apb_req_i.pwrite && is_font_w;
    end

    // ram read data lands one cycle after the first access cycle
    always_ff @(posedge clk_pxl_i) begin
        if (reset_i) begin
            rd_wait_r <= 1'b0;
        end else begin
            rd_wait_r <= mem_rd_w && !rd_wait_r;
        end
    end

    always_ff @(posedge clk_pxl_i) begin
        if (reset_i) begin
            enable_r <= 1'b0;
        end else if (access_w && apb_req_i.pwrite && is_ctrl_w) begin
            enable_r <= apb_req_i.pwdata[0];
        end
    end

    assign enable_o = enable_r;

    // response
    always_comb begin
        apb_rsp_o.pready  = access_w && (mem_rd_w ? rd_wait_r : 1'b1);
        apb_rsp_o.pslverr = access_w && is_unmapped_w;

        if (is_scr_w) begin
            apb_rsp_o.prdata = {24'b0, scr_rdata_i};
        end else if (is_font_w) begin
            apb_rsp_o.prdata = font_rdata_i;
        end else if (is_ctrl_w) begin
            apb_rsp_o.prdata = {31'b0, enable_r};
        end else begin
            apb_rsp_o.prdata = 32'b0;
        end
    end

endmodule

`default_nettype wire

/* logic/vga_controller.sv */
`timescale 1ns/1ns
`default_nettype none

module vga_controller (
    input  wire logic               clk_pxl_i,
    input  wire logic               reset_i,
    input  wire logic               enable_i,

    // screen memory, port b
    output      common::mem_addr_t  scr_addr_o,
    input  wire common::char_code_t scr_data_i,

    // font memory, port b
    output      common::mem_addr_t  font_addr_o,
    input  wire common::glyph_row_t font_data_i,

    output      common::vga_out_t   vga_o
);

    // x_r/y_r is the pixel on the outputs, x_w/y_w the one being built
    logic [9:0] x_r;
    logic [9:0] y_r;
    logic [9:0] x_w;
    logic [9:0] y_w;

    // one tile ahead, for the memory fetch
    logic [9:0] x_look_w;
    logic [9:0] y_look_w;

    logic [2:0]         tile_off_w;
    logic               active_w;
    logic               hsync_w;
    logic               vsync_w;
    common::glyph_row_t glyph_r;
    common::glyph_row_t shifted_w;
    logic [3:0]         pixel_w;

    always_comb begin
        x_w = x_r + 10'd1;
        y_w = y_r;
        if (x_w >= common::H_TOTAL) begin
            x_w = x_w - common::H_TOTAL;
            y_w = y_r + 10'd1;
        end
        if (y_w >= common::V_TOTAL) begin
            y_w = 10'd0;
        end
    end

    always_comb begin
        x_look_w = x_r + common::FETCH_AHEAD;
        y_look_w = y_r;
        if (x_look_w >= common::H_TOTAL) begin
            x_look_w = x_look_w - common::H_TOTAL;
            y_look_w = y_r + 10'd1;
        end
        if (y_look_w >= common::V_TOTAL) begin
            y_look_w = 10'd0;
        end
    end

    // start at the last pixel so the first free edge shows (0,0)
    always_ff @(posedge clk_pxl_i) begin
        if (reset_i) begin
            x_r <= common::H_TOTAL - 10'd1;
            y_r <= common::V_TOTAL - 10'd1;
        end else begin
            x_r <= x_w;
            y_r <= y_w;
        end
    end

    // fetch: screen word, then glyph row from the returned code
    always_comb begin
        scr_addr_o  = {y_look_w[8:4], x_look_w[9:3]};
        font_addr_o = {scr_data_i, y_look_w[3:0]};
    end

    assign tile_off_w = x_w[2:0];

    // glyph row arrives just as the current tile ends
    always_ff @(posedge clk_pxl_i) begin
        if (tile_off_w == 3'd7) begin
            glyph_r <= font_data_i;
        end
    end

    always_comb begin
        shifted_w = glyph_r << {tile_off_w, 2'b00};
        pixel_w   = shifted_w[31:28];
    end

    always_comb begin
        active_w = (x_w < common::H_ACTIVE) && (y_w < common::V_ACTIVE);
        hsync_w  = (x_w >= common::H_SYNC_START) && (x_w < common::H_SYNC_END);
        vsync_w  = (y_w >= common::V_SYNC_START) && (y_w < common::V_SYNC_END);
    end

    // outputs registered, grey level on all three guns
    always_ff @(posedge clk_pxl_i) begin
        if (reset_i) begin
            vga_o.red     <= 4'd0;
            vga_o.green   <= 4'd0;
            vga_o.blue    <= 4'd0;
            vga_o.hsync_n <= 1'b1;
            vga_o.vsync_n <= 1'b1;
        end else begin
            vga_o.red     <= (active_w && enable_i) ? pixel_w : 4'd0;
            vga_o.green   <= (active_w && enable_i) ? pixel_w : 4'd0;
            vga_o.blue    <= (active_w && enable_i) ? pixel_w : 4'd0;
            vga_o.hsync_n <= !hsync_w;
            vga_o.vsync_n <= !vsync_w;
        end
    end

endmodule

`default_nettype wire

/* logic/text_display_top.sv */
`timescale 1ns/1ns
`default_nettype none

module text_display_top #(
    parameter int MEM_DEPTH = 4096
) (
    input  wire logic             clk_pxl_i,
    input  wire logic             reset_i,
    input  wire common::apb_req_t apb_req_i,
    output      common::apb_rsp_t apb_rsp_o,
    output      common::vga_out_t vga_o
);

    // bus side
    logic               scr_we;
    logic               font_we;
    common::mem_addr_t  mem_addr;
    logic [31:0]        mem_wdata;
    common::char_code_t scr_rdata;
    common::glyph_row_t font_rdata;
    logic               enable;

    // video side
    common::mem_addr_t  scr_addr;
    common::char_code_t scr_data;
    common::mem_addr_t  font_addr;
    common::glyph_row_t font_data;

    apb_text_port port_inst (
        .clk_pxl_i   (clk_pxl_i),
        .reset_i     (reset_i),
        .apb_req_i   (apb_req_i),
        .apb_rsp_o   (apb_rsp_o),
        .scr_we_o    (scr_we),
        .font_we_o   (font_we),
        .mem_addr_o  (mem_addr),
        .mem_wdata_o (mem_wdata),
        .scr_rdata_i (scr_rdata),
        .font_rdata_i(font_rdata),
        .enable_o    (enable)
    );

    // character codes, one byte per tile
    dual_port_ram #(
        .payload_t(common::char_code_t),
        .DEPTH    (MEM_DEPTH)
    ) screen_ram_inst (
        .clk_pxl_i(clk_pxl_i),
        .a_we_i   (scr_we),
        .a_addr_i (mem_addr),
        .a_wdata_i(mem_wdata[7:0]),
        .a_rdata_o(scr_rdata),
        .b_addr_i (scr_addr),
        .b_rdata_o(scr_data)
    );

    // soft font, 16 rows per glyph
    dual_port_ram #(
        .payload_t(common::glyph_row_t),
        .DEPTH    (MEM_DEPTH)
    ) font_ram_inst (
        .clk_pxl_i(clk_pxl_i),
        .a_we_i   (font_we),
        .a_addr_i (mem_addr),
        .a_wdata_i(mem_wdata),
        .a_rdata_o(font_rdata),
        .b_addr_i (font_addr),
        .b_rdata_o(font_data)
    );

    vga_controller vga_inst (
        .clk_pxl_i  (clk_pxl_i),
        .reset_i    (reset_i),
        .enable_i   (enable),
        .scr_addr_o (scr_addr),
        .scr_data_i (scr_data),
        .font_addr_o(font_addr),
        .font_data_i(font_data),
        .vga_o      (vga_o)
    );

endmodule

`default_nettype wire

/* dv/text_display_tb_chk.sv */
`timescale 1ns/1ns
`default_nettype none

module text_display_tb_chk (
    input  wire logic             clk_pxl_i,
    input  wire logic             reset_i,
    input  wire common::apb_req_t apb_req_i,
    input  wire common::apb_rsp_t apb_rsp_i,
    input  wire common::vga_out_t vga_i
);

    pready_in_access: assert property (
        @(posedge clk_pxl_i) disable iff (reset_i)
        apb_rsp_i.pready |-> (apb_req_i.psel && apb_req_i.penable)
    ) else $error("pready high outside an apb access phase");

    // grey level only
    rgb_equal: assert property (
        @(posedge clk_pxl_i) disable iff (reset_i)
        (vga_i.red == vga_i.green) && (vga_i.green == vga_i.blue)
    ) else $error("red, green and blue differ");

    rgb_dark_in_sync: assert property (
        @(posedge clk_pxl_i) disable iff (reset_i)
        (!vga_i.hsync_n || !vga_i.vsync_n) |-> ({vga_i.red, vga_i.green, vga_i.blue} == 12'd0)
    ) else $error("rgb not zero during a sync pulse");

    slverr_with_pready: assert property (
        @(posedge clk_pxl_i) disable iff (reset_i)
        apb_rsp_i.pslverr |-> apb_rsp_i.pready
    ) else $error("pslverr high without pready");

endmodule

bind text_display_top text_display_tb_chk chk_inst (
    .clk_pxl_i(clk_pxl_i),
    .reset_i  (reset_i),
    .apb_req_i(apb_req_i),
    .apb_rsp_i(apb_rsp_o),
    .vga_i    (vga_o)
);

`default_nettype wire

/* dv/text_display_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module text_display_tb;

    localparam int CLK_PERIOD     = 40;
    localparam int LINE_PX        = int'(common::H_TOTAL);
    localparam int FRAME_CYCLES   = LINE_PX * int'(common::V_TOTAL);
    // frames passed from reset to the end of the last scan
    localparam int FRAMES_SPANNED = 8;
    localparam int BUS_XFERS      = 2 * 4096 + 200 + 16;
    localparam longint WATCHDOG_NS =
        (longint'(FRAMES_SPANNED + 2) * FRAME_CYCLES + longint'(BUS_XFERS) * 4) * CLK_PERIOD;

    logic             clk_pxl_i;
    logic             reset_i;
    common::apb_req_t apb_req;
    common::apb_rsp_t apb_rsp;
    common::vga_out_t vga;

    // model of what the host has loaded
    logic [7:0]  scr_model [4096];
    logic [31:0] font_model [4096];
    logic        model_enable;

    // pixel now on the video outputs
    int frame_pos;

    int checks;
    int errors;
    int errors_at_start;
    int tests_run;
    int tests_failed;

    text_display_top #(
        .MEM_DEPTH(4096)
    ) uut (
        .clk_pxl_i(clk_pxl_i),
        .reset_i  (reset_i),
        .apb_req_i(apb_req),
        .apb_rsp_o(apb_rsp),
        .vga_o    (vga)
    );

    initial begin
        clk_pxl_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_pxl_i = ~clk_pxl_i;
    end

    always @(posedge clk_pxl_i) begin
        if (reset_i) begin
            frame_pos <= FRAME_CYCLES - 1;
        end else if (frame_pos == FRAME_CYCLES - 1) begin
            frame_pos <= 0;
        end else begin
            frame_pos <= frame_pos + 1;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the run did not finish in time");
        $display(">>> FAIL");
        $finish;
    end

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors != errors_at_start) begin
            tests_failed++;
            $display("test %s: failed, %0d mismatches", name, errors - errors_at_start);
        end else begin
            $display("test %s: passed", name);
        end
        errors_at_start = errors;
    endtask

    task automatic apb_transfer(input logic is_write, input logic [13:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic slverr, output int waits);
        @(posedge clk_pxl_i);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= is_write;
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= wdata;
        @(posedge clk_pxl_i);
        apb_req.penable <= 1'b1;
        waits = 0;
        // request held until pready
        @(negedge clk_pxl_i);
        while (!apb_rsp.pready) begin
            waits++;
            @(negedge clk_pxl_i);
        end
        rdata  = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        @(posedge clk_pxl_i);
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
    endtask

    task automatic bus_write(input string name, input logic [13:0] addr, input logic [31:0] data);
        logic [31:0] rd;
        logic        err;
        int          waits;
        apb_transfer(1'b1, addr, data, rd, err, waits);
        compare_value(name, 32'd0, 32'(waits));
        compare_value(name, 32'd0, 32'(err));
    endtask

    task automatic bus_read(input string name, input logic [13:0] addr,
                            input logic [31:0] expected, input int exp_waits);
        logic [31:0] rd;
        logic        err;
        int          waits;
        apb_transfer(1'b0, addr, 32'd0, rd, err, waits);
        compare_value(name, expected, rd);
        compare_value(name, 32'(exp_waits), 32'(waits));
        compare_value(name, 32'd0, 32'(err));
    endtask

    function automatic logic [3:0] glyph_nibble(input logic [9:0] x, input logic [9:0] y);
        logic [7:0]  code;
        logic [31:0] row;
        int          shift;
        // 8x16 tiles, screen rows at a pitch of 128
        code  = scr_model[12'(int'(y) / 16 * 128 + int'(x) / 8)];
        row   = font_model[12'(int'(code) * 16 + int'(y) % 16)];
        shift = 28 - 4 * (int'(x) % 8);
        return 4'(row >> shift);
    endfunction

    // waits for pixel (0,0) and checks every pixel of that frame
    task automatic scan_frame(input string name);
        logic [9:0] x;
        logic [9:0] y;
        logic       hs_n;
        logic       vs_n;
        logic [3:0] nib;
        @(negedge clk_pxl_i);
        while (frame_pos != 0) begin
            @(negedge clk_pxl_i);
        end
        for (int i = 0; i < FRAME_CYCLES; i++) begin
            x    = 10'(i % LINE_PX);
            y    = 10'(i / LINE_PX);
            hs_n = !(x >= common::H_SYNC_START && x < common::H_SYNC_END);
            vs_n = !(y >= common::V_SYNC_START && y < common::V_SYNC_END);
            nib  = 4'd0;
            if (model_enable && x < common::H_ACTIVE && y < common::V_ACTIVE) begin
                nib = glyph_nibble(x, y);
            end
            compare_value(name, 32'({hs_n, vs_n}), 32'({vga.hsync_n, vga.vsync_n}));
            compare_value(name, 32'({nib, nib, nib}), 32'({vga.red, vga.green, vga.blue}));
            @(negedge clk_pxl_i);
        end
    endtask

    initial begin
        logic [31:0] wd;
        logic [31:0] rd;
        logic [11:0] a;
        logic        err;
        int          waits;
        int          idx;

        void'($urandom(32'hf93d));
        reset_i      <= 1'b1;
        apb_req      <= '0;
        model_enable = 1'b0;
        repeat (2) @(posedge clk_pxl_i);
        reset_i <= 1'b0;

        // screen data carries random upper bits to catch missing zero-extension
        for (int i = 0; i < 4096; i++) begin
            wd = $urandom();
            scr_model[12'(i)] = wd[7:0];
            bus_write("bus_readback", {common::REGION_SCREEN, 12'(i)}, wd);
            wd = $urandom();
            font_model[12'(i)] = wd;
            bus_write("bus_readback", {common::REGION_FONT, 12'(i)}, wd);
        end
        for (int i = 0; i < 100; i++) begin
            a = 12'($urandom());
            bus_read("bus_readback", {common::REGION_SCREEN, a}, {24'd0, scr_model[a]}, 1);
            a = 12'($urandom());
            bus_read("bus_readback", {common::REGION_FONT, a}, font_model[a], 1);
        end
        finish_test("bus_readback");

        // enable still clear
        scan_frame("sync_timing");
        finish_test("sync_timing");

        bus_write("text_rendering", {common::REGION_CTRL, 12'd0}, 32'd1);
        model_enable = 1'b1;
        scan_frame("text_rendering");
        finish_test("text_rendering");

        bus_write("blanking", {common::REGION_CTRL, 12'd0}, 32'd0);
        model_enable = 1'b0;
        bus_read("blanking", {common::REGION_CTRL, 12'd0}, 32'd0, 0);
        scan_frame("blanking");
        finish_test("blanking");

        bus_write("error_response", {common::REGION_CTRL, 12'd0}, 32'd1);
        model_enable = 1'b1;
        a  = 12'($urandom());
        // bit 0 low, so a stray control write would clear enable
        wd = {24'd0, ~scr_model[a][7:1], 1'b0};
        apb_transfer(1'b1, {2'b11, a}, wd, rd, err, waits);
        compare_value("error_response", 32'd1, 32'(err));
        compare_value("error_response", 32'd0, 32'(waits));
        apb_transfer(1'b0, {2'b11, a}, 32'd0, rd, err, waits);
        compare_value("error_response", 32'd1, 32'(err));
        compare_value("error_response", 32'd0, 32'(waits));
        bus_read("error_response", {common::REGION_CTRL, 12'd0}, 32'd1, 0);
        bus_read("error_response", {common::REGION_SCREEN, a}, {24'd0, scr_model[a]}, 1);
        bus_read("error_response", {common::REGION_FONT, a}, font_model[a], 1);
        finish_test("error_response");

        // new code lands mid-frame, visible from the next frame
        idx = int'($urandom() % 30) * 128 + int'($urandom() % 80);
        @(negedge clk_pxl_i);
        while (frame_pos != FRAME_CYCLES / 2) begin
            @(negedge clk_pxl_i);
        end
        wd = {24'd0, scr_model[12'(idx)] ^ 8'(1 + $urandom() % 255)};
        scr_model[12'(idx)] = wd[7:0];
        bus_write("live_update", {common::REGION_SCREEN, 12'(idx)}, wd);
        scan_frame("live_update");
        finish_test("live_update");

        $display("tests %0d, failed %0d, checks %0d, mismatches %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
logic/common.sv
logic/dual_port_ram.sv
logic/apb_text_port.sv
logic/vga_controller.sv
logic/text_display_top.sv
dv/text_display_tb_chk.sv
dv/text_display_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := text_display_tb
FILELIST  := tb.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q '>>> PASS' $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
